// File: ej32_apb_host.sv
/* APB slave of the core. Decodes the register map and the program memory
   window, keeps the start address and the running flag. Zero wait states. */
`timescale 1ns/1ps

module ej32_apb_host
    import ej32_pkg::*;
#(
    parameter int MEM_BYTES = 1024
) (
    input  logic       ctl,
    input  logic       arst_n,
    input  iu_t        paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  du_t        pwdata,
    input  logic       halted,
    input  logic       fault,
    input  logic [3:0] depth,
    input  du_t        tos,
    input  logic       fetch_done,
    output du_t        prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       mem_we,
    output iu_t        mem_waddr,
    output u8_t        mem_wdata,
    output logic       start,
    output iu_t        start_addr
);

    logic        access;
    logic        is_ctrl;
    logic        is_status;
    logic        is_tos;
    logic        is_start;
    logic        is_win;
    logic        mapped;
    logic        busy;          // core or fetch still active
    logic        wr_ok;
    logic        running;
    logic [16:0] addr_x;

    assign access    = psel && penable;
    assign pready    = 1'b1;
    assign is_ctrl   = (paddr == REG_CTRL);
    assign is_status = (paddr == REG_STATUS);
    assign is_tos    = (paddr == REG_TOS);
    assign is_start  = (paddr == REG_START);
    assign addr_x    = {1'b0, paddr};
    assign is_win    = (addr_x >= 17'(MEM_BASE))
                       && (addr_x < 17'(MEM_BASE) + 17'(MEM_BYTES));
    assign mapped    = is_ctrl || is_status || is_tos || is_start || is_win;
    assign busy      = running || !fetch_done;
    assign pslverr   = access && (!mapped || (pwrite && (is_win || is_start) && busy));
    assign wr_ok     = access && pwrite && !pslverr;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_STATUS: prdata = {20'b0, depth, 5'b0, fault, halted, running};
                REG_TOS:    prdata = tos;
                REG_START:  prdata = du_t'(start_addr);
                default: ;
            endcase
        end
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            running    <= 1'b0;
            start      <= 1'b0;
            start_addr <= '0;
            mem_we     <= 1'b0;
        end else begin
            start  <= wr_ok && is_ctrl && pwdata[0] && !running;    // one-cycle pulse
            mem_we <= wr_ok && is_win;
            if (wr_ok && is_start) start_addr <= pwdata[15:0];
            if (start) running <= 1'b1;
            else if (halted) running <= 1'b0;
        end
    end

    always_ff @(posedge ctl) begin
        mem_waddr <= paddr - MEM_BASE;
        mem_wdata <= pwdata[7:0];
    end

    a_apb_setup: assert property (@(posedge ctl) disable iff (!arst_n)
        penable |-> $past(psel))
        else $error("penable without a setup phase");

endmodule

// File: ej32_au.sv
/* Arithmetic unit. Pops operation words from the queue and runs them on a
   bounded data stack; return halts, a bad word or stack error faults. */
`timescale 1ns/1ps

module ej32_au
    import ej32_pkg::*;
#(
    parameter int STACK_DEPTH = 8
) (
    input  logic       ctl,
    input  logic       arst_n,
    input  logic       clear,
    input  logic       pop_valid,
    input  op_word_t   pop_word,
    output logic       pop_ready,
    output logic       halted,
    output logic       fault,
    output logic [3:0] depth,
    output du_t        tos
);

    localparam int SW = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    du_t           stk [STACK_DEPTH];
    logic          run;              // armed by clear, dropped on halt
    unit_e         unit;
    opcode_e       op;
    opnd_t         opnd;
    du_t           a;                // top
    du_t           b;                // second from top
    du_t           r0;
    du_t           r1;
    logic [1:0]    n_in;
    logic [1:0]    n_out;
    logic          known;
    logic          bad;
    logic [3:0]    base;             // lowest slot touched by the result
    logic          exec;

    assign unit      = unit_e'(pop_word[25:24]);
    assign op        = opcode_e'(pop_word[23:16]);
    assign opnd      = pop_word[15:0];
    assign a         = stk[SW'(depth - 4'd1)];
    assign b         = stk[SW'(depth - 4'd2)];
    assign tos       = (depth == 4'd0) ? '0 : a;
    assign pop_ready = run;
    assign exec      = pop_valid && run && !clear;
    assign base      = depth - 4'(n_in);
    assign bad       = (unit != unit_au) || !known || (depth < 4'(n_in))
                       || (5'(base) + 5'(n_out) > 5'(STACK_DEPTH));

    always_comb begin
        n_in  = 2'd0;
        n_out = 2'd1;
        known = 1'b1;
        r0    = '0;
        r1    = a;
        case (op)
            nop, vreturn: n_out = 2'd0;
            aconst_null: r0 = '0;
            iconst_m1, iconst_0, iconst_1, iconst_2, iconst_3, iconst_4, iconst_5:
                r0 = du_t'(op) - 32'd3;
            bipush: r0 = {{24{opnd[7]}}, opnd[7:0]};
            sipush: r0 = {{16{opnd[15]}}, opnd};
            pop: begin
                n_in  = 2'd1;
                n_out = 2'd0;
            end
            dup: begin
                n_in  = 2'd1;
                n_out = 2'd2;
                r0    = a;
            end
            swap: begin
                n_in  = 2'd2;
                n_out = 2'd2;
                r0    = a;
                r1    = b;
            end
            ineg: begin
                n_in = 2'd1;
                r0   = -a;
            end
            iadd, isub, ishl, ishr, iushr, iand, ior, ixor: begin
                n_in = 2'd2;    // b is the left operand
                case (op)
                    iadd:    r0 = b + a;
                    isub:    r0 = b - a;
                    ishl:    r0 = b << a[4:0];
                    ishr:    r0 = du_t'($signed(b) >>> a[4:0]);
                    iushr:   r0 = b >> a[4:0];
                    iand:    r0 = b & a;
                    ior:     r0 = b | a;
                    default: r0 = b ^ a;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            run    <= 1'b0;
            halted <= 1'b0;
            fault  <= 1'b0;
            depth  <= '0;
        end else if (clear) begin
            run    <= 1'b1;
            halted <= 1'b0;
            fault  <= 1'b0;
            depth  <= '0;
        end else if (exec) begin
            if (bad) begin
                run    <= 1'b0;
                halted <= 1'b1;
                fault  <= 1'b1;
            end else if (op == vreturn) begin
                run    <= 1'b0;
                halted <= 1'b1;
            end else begin
                depth <= base + 4'(n_out);
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (exec && !bad && n_out != 2'd0) begin
            stk[SW'(base)] <= r0;
            if (n_out == 2'd2) stk[SW'(base + 4'd1)] <= r1;
        end
    end

    a_depth_bound: assert property (@(posedge ctl) disable iff (!arst_n)
        depth <= 4'(STACK_DEPTH))
        else $error("stack depth above STACK_DEPTH");

endmodule

// File: ej32_fetch.sv
/* Fetch and decode. Reads bytecode from the start address, gathers the
   bipush/sipush operands and pushes one operation word per instruction. */
`timescale 1ns/1ps

module ej32_fetch
    import ej32_pkg::*;
(
    input  logic     ctl,
    input  logic     arst_n,
    input  logic     start,
    input  iu_t      start_addr,
    input  u8_t      rd_data,
    input  logic     push_ready,
    output logic     rd_en,
    output iu_t      rd_addr,
    output logic     push_valid,
    output op_word_t push_word,
    output logic     fetch_done
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_operand,
        st_push,
        st_done
    } state_e;

    state_e     state;
    iu_t        pc;
    logic [1:0] opnd_left;    // operand bytes still to read
    u8_t        code;
    unit_e      unit;
    opnd_t      opnd;
    logic       last;         // stop after this word

    // sort an opcode to the unit that would run it
    function automatic unit_e classify(u8_t b);
        unit_e u;
        case (b) inside
            nop, aconst_null, iconst_m1, iconst_0, iconst_1, iconst_2, iconst_3,
            iconst_4, iconst_5, bipush, sipush, pop, dup, swap, iadd, isub, ineg,
            ishl, ishr, iushr, iand, ior, ixor, vreturn:
                u = unit_au;
            8'h15, [8'h1a:8'h1d], 8'h3b, 8'h84, [8'h99:8'ha9], 8'hb6:
                u = unit_br;    // locals, conditionals, goto, jsr, invoke
            8'h2e, 8'h33, 8'h35, 8'h4f, 8'h54, 8'h56:
                u = unit_ls;    // array loads and stores
            default:
                u = unit_bad;
        endcase
        return u;
    endfunction

    assign rd_en      = (state == st_addr);
    assign rd_addr    = pc;
    assign push_valid = (state == st_push);
    assign push_word  = {unit, code, opnd};
    assign fetch_done = (state == st_idle) || (state == st_done);
    assign last       = (code == vreturn) || (unit != unit_au);

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            pc        <= '0;
            opnd_left <= '0;
        end else if (start) begin
            state     <= st_addr;
            pc        <= start_addr;
            opnd_left <= '0;
        end else begin
            case (state)
                st_addr: begin
                    pc    <= pc + 1'b1;
                    state <= (opnd_left != 2'd0) ? st_operand : st_data;
                end
                st_data: begin
                    if (rd_data == bipush) begin
                        opnd_left <= 2'd1;
                        state     <= st_addr;
                    end else if (rd_data == sipush) begin
                        opnd_left <= 2'd2;
                        state     <= st_addr;
                    end else begin
                        state <= st_push;
                    end
                end
                st_operand: begin
                    opnd_left <= opnd_left - 1'b1;
                    state     <= (opnd_left == 2'd1) ? st_push : st_addr;
                end
                st_push: begin
                    if (push_ready) begin
                        state <= last ? st_done : st_addr;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (state == st_data) begin
            code <= rd_data;
            unit <= classify(rd_data);
            opnd <= '0;
        end else if (state == st_operand) begin
            opnd <= {opnd[7:0], rd_data};    // high byte first
        end
    end

    a_push_hold: assert property (@(posedge ctl) disable iff (!arst_n)
        push_valid && !push_ready && !start |=> push_valid && $stable(push_word))
        else $error("operation word changed while stalled");

endmodule

// File: ej32_op_queue.sv
/* Operation queue between fetch and the arithmetic unit. A circular buffer
   with valid/ready on both sides. flush empties it when the core starts. */
`timescale 1ns/1ps

module ej32_op_queue
    import ej32_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     ctl,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     push_valid,
    input  op_word_t push_word,
    input  logic     pop_ready,
    output logic     push_ready,
    output logic     pop_valid,
    output op_word_t pop_word
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    op_word_t      slots [QUEUE_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push_fire;
    logic          pop_fire;

    function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] p);
        return (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ready = (count != CW'(QUEUE_DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_word   = slots[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= next_ptr(wr_ptr);
            if (pop_fire) rd_ptr <= next_ptr(rd_ptr);
            if (push_fire && !pop_fire) count <= count + 1'b1;
            else if (pop_fire && !push_fire) count <= count - 1'b1;
        end
    end

    always_ff @(posedge ctl) begin
        if (push_fire) slots[wr_ptr] <= push_word;
    end

    a_count_bound: assert property (@(posedge ctl) disable iff (!arst_n)
        count <= CW'(QUEUE_DEPTH))
        else $error("queue count above depth");
    a_no_push_full: assert property (@(posedge ctl) disable iff (!arst_n)
        count == CW'(QUEUE_DEPTH) && !flush |=> $stable(wr_ptr))
        else $error("push accepted while full");

endmodule

// File: ej32_pkg.sv
/* Shared types, opcode and unit encodings and the host register map of the
   eJ32 arithmetic slice. Every design file imports it in its module header. */
package ej32_pkg;

    typedef logic [7:0]  u8_t;         // bytecode or memory byte
    typedef logic [15:0] iu_t;         // program memory address
    typedef logic [31:0] du_t;         // stack data word
    typedef logic [15:0] opnd_t;       // raw immediate, big-endian from memory
    typedef logic [25:0] op_word_t;    // {unit[25:24], opcode[23:16], operand[15:0]}

    typedef enum logic [1:0] {
        unit_au,
        unit_br,
        unit_ls,
        unit_bad
    } unit_e;

    // standard JVM encodings of the opcodes the arithmetic unit runs
    typedef enum logic [7:0] {
        nop         = 8'h00,
        aconst_null = 8'h01,
        iconst_m1   = 8'h02,
        iconst_0    = 8'h03,
        iconst_1    = 8'h04,
        iconst_2    = 8'h05,
        iconst_3    = 8'h06,
        iconst_4    = 8'h07,
        iconst_5    = 8'h08,
        bipush      = 8'h10,
        sipush      = 8'h11,
        pop         = 8'h57,
        dup         = 8'h59,
        swap        = 8'h5f,
        iadd        = 8'h60,
        isub        = 8'h64,
        ineg        = 8'h74,
        ishl        = 8'h78,
        ishr        = 8'h7a,
        iushr       = 8'h7c,
        iand        = 8'h7e,
        ior         = 8'h80,
        ixor        = 8'h82,
        vreturn     = 8'hb1        // void return, ends the program
    } opcode_e;

    // APB register map
    localparam iu_t REG_CTRL   = 16'h0000;    // bit 0 starts the core
    localparam iu_t REG_STATUS = 16'h0004;    // running, halted, fault, depth
    localparam iu_t REG_TOS    = 16'h0008;
    localparam iu_t REG_START  = 16'h000C;
    localparam iu_t MEM_BASE   = 16'h1000;    // program memory window

endpackage

// File: ej32_prog_mem.sv
/* Byte-wide program memory. The host port writes bytecode, fetch reads it
   back with one cycle of latency. Addresses wrap at MEM_BYTES. */
`timescale 1ns/1ps

module ej32_prog_mem
    import ej32_pkg::*;
#(
    parameter int MEM_BYTES = 1024
) (
    input  logic ctl,
    input  logic we,
    input  iu_t  waddr,
    input  u8_t  wdata,
    input  logic rd_en,
    input  iu_t  rd_addr,
    output u8_t  rd_data
);

    localparam int AW = (MEM_BYTES > 1) ? $clog2(MEM_BYTES) : 1;

    u8_t           mem [MEM_BYTES];
    logic [AW-1:0] widx;
    logic [AW-1:0] ridx;

    assign widx = AW'(waddr % MEM_BYTES);
    assign ridx = AW'(rd_addr % MEM_BYTES);

    always_ff @(posedge ctl) begin
        if (we) begin
            mem[widx] <= wdata;
        end
        if (rd_en) begin
            rd_data <= mem[ridx];    // valid the cycle after rd_en
        end
    end

    // host loads only while fetch is stopped
    a_no_rw_clash: assert property (@(posedge ctl) !(we && rd_en))
        else $error("program memory written and read in the same cycle");

endmodule

// File: ej32_top.sv
/* Top of the eJ32 arithmetic slice. An APB host loads the program memory
   and starts fetch, which feeds the arithmetic unit through a queue. */
`timescale 1ns/1ps

module ej32_top
    import ej32_pkg::*;
#(
    parameter int MEM_BYTES   = 1024,
    parameter int QUEUE_DEPTH = 4,
    parameter int STACK_DEPTH = 8
) (
    input  logic ctl,
    input  logic arst_n,
    input  iu_t  paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  du_t  pwdata,
    output du_t  prdata,
    output logic pready,
    output logic pslverr
);

    logic       mem_we;
    iu_t        mem_waddr;
    u8_t        mem_wdata;
    logic       start;          // also flushes the queue and clears the AU
    iu_t        start_addr;
    logic       rd_en;
    iu_t        rd_addr;
    u8_t        rd_data;
    logic       push_valid;
    logic       push_ready;
    op_word_t   push_word;
    logic       pop_valid;
    logic       pop_ready;
    op_word_t   pop_word;
    logic       halted;
    logic       fault;
    logic       fetch_done;
    logic [3:0] depth;
    du_t        tos;

    ej32_apb_host #(.MEM_BYTES(MEM_BYTES)) u_host (.*);

    ej32_prog_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .ctl    (ctl),
        .we     (mem_we),
        .waddr  (mem_waddr),
        .wdata  (mem_wdata),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    ej32_fetch u_fetch (.*);

    ej32_op_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .flush(start),
        .*
    );

    ej32_au #(.STACK_DEPTH(STACK_DEPTH)) u_au (
        .clear(start),
        .*
    );

endmodule

// File: project.f
ej32_pkg.sv
ej32_prog_mem.sv
ej32_fetch.sv
ej32_op_queue.sv
ej32_au.sv
ej32_apb_host.sv
ej32_top.sv
tb_ej32.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ej32 \
    -f project.f -o sim_ej32

./obj_dir/sim_ej32 | tee sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_ej32.sv
/* Testbench of the eJ32 arithmetic slice. Loads bytecode over APB, runs it
   and checks status and top of stack against a software stack model. */
`timescale 1ns/1ps

module tb_ej32
    import ej32_pkg::*;
();

    localparam int MEM_BYTES   = 1024;
    localparam int QUEUE_DEPTH = 4;
    localparam int STACK_DEPTH = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 25;

    logic ctl;
    logic arst_n;
    iu_t  paddr;
    logic psel;
    logic penable;
    logic pwrite;
    du_t  pwdata;
    du_t  prdata;
    logic pready;
    logic pslverr;

    logic  chk_data;    // compare the next read with exp_data
    du_t   exp_data;
    logic  exp_err;     // pslverr expected in the access phase
    int    errors;
    int    test_errs;
    int    passed;
    int    failed;
    int    test_no;
    string test_name;
    u8_t   prog[$];     // bytecode of the current test
    du_t   m_tos;
    int    m_depth;
    bit    m_fault;

    ej32_top #(
        .MEM_BYTES  (MEM_BYTES),
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .STACK_DEPTH(STACK_DEPTH)
    ) u_ej32_top (
        .ctl    (ctl),
        .arst_n (arst_n),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    always #(CLK_PERIOD / 2) ctl = ~ctl;

    task automatic note_fail(input string msg);
        errors++;
        test_errs++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    a_read_value: assert property (@(posedge ctl) disable iff (!arst_n)
        psel && penable && !pwrite && chk_data |-> prdata == exp_data)
        else note_fail($sformatf("read of 0x%04h gave 0x%08h, model 0x%08h",
                                 $sampled(paddr), $sampled(prdata), $sampled(exp_data)));
    a_slverr: assert property (@(posedge ctl) disable iff (!arst_n)
        psel && penable |-> pslverr == exp_err)
        else note_fail($sformatf("pslverr %0b at 0x%04h, expected %0b",
                                 $sampled(pslverr), $sampled(paddr), $sampled(exp_err)));
    a_ready: assert property (@(posedge ctl) disable iff (!arst_n)
        psel && penable |-> pready)
        else note_fail("pready low in an access phase");

    task automatic apb_xfer(input iu_t addr, input logic wr, input du_t wdata,
                            output du_t rdata);
        @(posedge ctl);
        #1;
        paddr   = addr;    // setup phase
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge ctl);
        #1;
        penable = 1'b1;
        @(negedge ctl);
        rdata = prdata;    // mid access phase
        @(posedge ctl);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input iu_t addr, input du_t data);
        du_t unused;
        apb_xfer(addr, 1'b1, data, unused);
    endtask

    task automatic apb_read(input iu_t addr, output du_t data);
        apb_xfer(addr, 1'b0, '0, data);
    endtask

    task automatic check_read(input iu_t addr, input du_t expected);
        du_t d;
        chk_data = 1'b1;
        exp_data = expected;
        apb_read(addr, d);
        chk_data = 1'b0;
    endtask

    // stack machine after the register map rules, stops at return or a fault
    function automatic void model_run(input u8_t p[$]);
        du_t s[$];
        du_t x;
        du_t y;
        du_t imm;
        u8_t op;
        int  pc;
        int  need;
        int  gives;
        bit  known;
        bit  done;
        pc      = 0;
        done    = 0;
        m_fault = 0;
        while (!done && pc < p.size()) begin
            op    = p[pc];
            pc++;
            need  = 0;
            gives = 1;
            imm   = '0;
            known = 1;
            case (op) inside
                nop, vreturn: gives = 0;
                aconst_null: imm = '0;
                [iconst_m1:iconst_5]: imm = du_t'(int'(op) - 3);
                bipush: begin
                    imm = {{24{p[pc][7]}}, p[pc]};
                    pc += 1;
                end
                sipush: begin
                    imm = {{16{p[pc][7]}}, p[pc], p[pc + 1]};    // big-endian
                    pc += 2;
                end
                pop: begin
                    need  = 1;
                    gives = 0;
                end
                dup: begin
                    need  = 1;
                    gives = 2;
                end
                swap: begin
                    need  = 2;
                    gives = 2;
                end
                ineg: need = 1;
                iadd, isub, ishl, ishr, iushr, iand, ior, ixor: need = 2;
                default: known = 0;
            endcase
            if (!known || s.size() < need || s.size() - need + gives > STACK_DEPTH) begin
                m_fault = 1;
                done    = 1;
            end else if (op == vreturn) begin
                done = 1;
            end else begin
                x = '0;
                y = '0;
                if (need > 0) x = s.pop_back();    // top
                if (need > 1) y = s.pop_back();    // left operand
                case (op)
                    nop, pop: ;
                    dup: begin
                        s.push_back(x);
                        s.push_back(x);
                    end
                    swap: begin
                        s.push_back(x);
                        s.push_back(y);
                    end
                    ineg:  s.push_back(-x);
                    iadd:  s.push_back(y + x);
                    isub:  s.push_back(y - x);
                    ishl:  s.push_back(y << x[4:0]);
                    ishr:  s.push_back(du_t'($signed(y) >>> x[4:0]));
                    iushr: s.push_back(y >> x[4:0]);
                    iand:  s.push_back(y & x);
                    ior:   s.push_back(y | x);
                    ixor:  s.push_back(y ^ x);
                    default: s.push_back(imm);
                endcase
            end
        end
        m_depth = s.size();
        m_tos   = (s.size() > 0) ? s[$] : '0;
    endfunction

    task automatic emit_push();
        case ($urandom_range(0, 2))
            0: prog.push_back(u8_t'(iconst_m1) + u8_t'($urandom_range(0, 6)));
            1: begin
                prog.push_back(bipush);
                prog.push_back(u8_t'($urandom));
            end
            default: begin
                prog.push_back(sipush);
                prog.push_back(u8_t'($urandom));
                prog.push_back(u8_t'($urandom));
            end
        endcase
    endtask

    // random program that never leaves the stack bounds
    task automatic gen_random_program();
        u8_t bin_ops[6] = '{iand, ior, ixor, ishl, ishr, iushr};
        int  d;
        int  len;
        bit  legal;
        prog.delete();
        d   = 0;
        len = 6 + $urandom_range(0, 14);
        for (int i = 0; i < len; i++) begin
            legal = 0;
            while (!legal) begin
                case ($urandom_range(0, 7))
                    0, 1, 2: if (d < STACK_DEPTH) begin
                        emit_push();
                        d++;
                        legal = 1;
                    end
                    3: if (d >= 1 && d < STACK_DEPTH) begin
                        prog.push_back(dup);
                        d++;
                        legal = 1;
                    end
                    4: if (d >= 2) begin
                        prog.push_back(swap);
                        legal = 1;
                    end
                    5: if (d >= 1) begin
                        prog.push_back(pop);
                        d--;
                        legal = 1;
                    end
                    default: if (d >= 2) begin
                        prog.push_back(bin_ops[$urandom_range(0, 5)]);
                        d--;
                        legal = 1;
                    end
                endcase
            end
        end
        prog.push_back(vreturn);
    endtask

    task automatic load_and_start(input iu_t base);
        foreach (prog[i]) begin
            apb_write(iu_t'(MEM_BASE + base + iu_t'(i)), du_t'(prog[i]));
        end
        apb_write(REG_START, du_t'(base));
        apb_write(REG_CTRL, 32'd1);
    endtask

    task automatic wait_halt();
        du_t st;
        st = '0;
        while (!st[1]) apb_read(REG_STATUS, st);
    endtask

    task automatic check_result();
        du_t st;
        model_run(prog);
        st       = '0;
        st[11:8] = 4'(m_depth);
        st[2]    = m_fault;
        st[1]    = 1'b1;    // halted, running already dropped
        check_read(REG_STATUS, st);
        check_read(REG_TOS, m_tos);
    endtask

    task automatic run_program(input iu_t base);
        load_and_start(base);
        wait_halt();
        check_result();
    endtask

    task automatic begin_test(input string name);
        test_no++;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            passed++;
            $display("test %0d %s: ok", test_no, test_name);
        end else begin
            failed++;
            $display("test %0d %s: %0d check(s) wrong", test_no, test_name, test_errs);
        end
    endtask

    initial begin
        du_t rd;
        void'($urandom(90288));
        ctl       = 1'b0;
        arst_n    = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        chk_data  = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        errors    = 0;
        test_errs = 0;
        passed    = 0;
        failed    = 0;
        test_no   = 0;
        repeat (3) @(posedge ctl);
        #1;
        arst_n = 1'b1;

        begin_test("reset state and host errors");
        check_read(REG_STATUS, '0);
        exp_err = 1'b1;
        apb_read(16'h0010, rd);    // hole in the map
        exp_err = 1'b0;
        prog.delete();
        repeat (10) prog.push_back(nop);
        prog.push_back(iconst_3);
        prog.push_back(vreturn);
        load_and_start(16'h0000);
        exp_err = 1'b1;
        apb_write(MEM_BASE + 16'd10, du_t'(iconst_5));    // would turn 3 into 5
        exp_err = 1'b0;
        wait_halt();
        check_result();
        end_test();

        begin_test("fixed arithmetic program");
        prog = '{bipush, 8'd100, sipush, 8'hfe, 8'hd4, iadd, iconst_4, isub, ineg,
                 bipush, 8'hfb, iadd, sipush, 8'h03, 8'he8, iconst_1, iadd, vreturn};
        run_program(16'h0100);
        end_test();

        for (int n = 0; n < 20; n++) begin
            begin_test($sformatf("random program %0d", n));
            gen_random_program();
            run_program(16'h0200);
            end_test();
        end

        begin_test("iadd underflow");
        prog = '{iconst_1, iadd, vreturn};
        run_program(16'h0300);
        end_test();

        begin_test("stack overflow");
        prog.delete();
        for (int i = 1; i <= 9; i++) begin
            prog.push_back(bipush);
            prog.push_back(u8_t'(i));
        end
        prog.push_back(vreturn);
        run_program(16'h0300);
        end_test();

        begin_test("branch opcode");
        prog = '{iconst_2, bipush, 8'd7, iadd, 8'ha7, 8'h00, 8'h03, iconst_1, vreturn};
        run_program(16'h0380);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 test_no, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, 2000 cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
